// ==== Bender.yml ====
package:
  name: barrel_wb

sources:
  # rtl, package first
  - files:
      - hw/barrel_wb_pkg.sv
      - hw/load_align.sv
      - hw/next_pc_calc.sv
      - hw/regfile_write_stage.sv
      - hw/barrel_wb_top.sv

  # testbench
  - target: test
    files:
      - verif/tb_barrel_wb.sv

# top levels: barrel_wb_top, tb_barrel_wb

// ==== hw/barrel_wb_pkg.sv ====
package barrel_wb_pkg;

    // ==================================================================
    // widths and counts
    // ==================================================================

    // data and pc width
    localparam int unsigned XLEN       = 32;
    // hart slots in the barrel
    localparam int unsigned NUM_HARTS  = 4;
    // hart index width, follows the slot count
    localparam int unsigned HART_W     = $clog2(NUM_HARTS);
    // x0..x31
    localparam int unsigned REG_ADDR_W = 5;
    // sequential fetch step, one 32-bit instruction
    localparam int unsigned PC_STEP    = 4;

    // ==================================================================
    // basic types
    // ==================================================================

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [HART_W-1:0]     hart_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // reduced opcode set seen by write-back
    // branch compare already resolved upstream, result lands in alu_res[0]
    typedef enum logic [3:0] {
        OP_NOP,
        OP_ALU,
        OP_LUI,
        OP_JAL,
        OP_JALR,
        OP_BRANCH,
        // loads
        OP_LB,
        OP_LH,
        OP_LW,
        OP_LBU,
        OP_LHU,
        // stores, no register write here
        OP_SB,
        OP_SH,
        OP_SW
    } opcode_e;

    // ==================================================================
    // pipeline words
    // ==================================================================

    // one instruction result entering write-back
    typedef struct packed {
        hart_t     hart;
        opcode_e   opcode;
        reg_addr_t rd;
        word_t     alu_res;
        word_t     rs1;
        word_t     imm;
        word_t     pc;
        // low two bits of the load address, picks the lane
        logic [1:0] addr_lo;
    } wb_in_t;

    // next-pc decision for the slot
    typedef struct packed {
        logic  has_new_pc;
        // jal / jalr, link goes to rd
        logic  save_pc;
        word_t link;
        word_t target;
    } npc_t;

    // register file write port
    typedef struct packed {
        logic      wen;
        hart_t     hart;
        reg_addr_t addr;
        word_t     data;
    } rf_write_t;

    // per-hart pc update toward fetch
    // computed low means fetch keeps its own pc plus 4
    typedef struct packed {
        logic  computed;
        hart_t hart;
        word_t pc;
    } pc_update_t;

endpackage

// ==== hw/barrel_wb_top.sv ====
module barrel_wb_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  barrel_wb_pkg::wb_in_t     wb_i,
    input  barrel_wb_pkg::word_t      dmem_rdata_i,
    output barrel_wb_pkg::rf_write_t  rf_write_o,
    output barrel_wb_pkg::pc_update_t pc_update_o
);
    import barrel_wb_pkg::*;

    // combinational results for the current slot
    word_t load_val;
    npc_t  npc;

    // ==================================================================
    // parallel units, same cycle as the slot
    // ==================================================================

    // lane pick from the data memory word
    load_align load_align_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .opcode_i   (wb_i.opcode),
        .addr_lo_i  (wb_i.addr_lo),
        .rdata_i    (dmem_rdata_i),
        .load_val_o (load_val)
    );

    // jump and branch resolution
    next_pc_calc next_pc_calc_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .wb_i  (wb_i),
        .npc_o (npc)
    );

    // registered rf write and pc update, one cycle later
    regfile_write_stage regfile_write_stage_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .wb_i        (wb_i),
        .load_val_i  (load_val),
        .npc_i       (npc),
        .rf_write_o  (rf_write_o),
        .pc_update_o (pc_update_o)
    );

endmodule

// ==== hw/load_align.sv ====
module load_align (
    input  logic                 clk,
    input  logic                 rst_n,
    input  barrel_wb_pkg::opcode_e opcode_i,
    input  logic [1:0]           addr_lo_i,
    input  barrel_wb_pkg::word_t rdata_i,
    output barrel_wb_pkg::word_t load_val_o
);
    import barrel_wb_pkg::*;

    logic [7:0]  byte_lane;
    logic [15:0] half_lane;
    logic        half_ok;

    // ==================================================================
    // lane select from the word-wide read
    // ==================================================================

    // byte lane by offset, little endian
    always_comb begin
        case (addr_lo_i)
            2'd0: byte_lane = rdata_i[7:0];
            2'd1: byte_lane = rdata_i[15:8];
            2'd2: byte_lane = rdata_i[23:16];
            default: byte_lane = rdata_i[31:24];
        endcase
    end

    // half lane, only offsets 0 and 2 are aligned
    assign half_ok   = (addr_lo_i[0] == 1'b0);
    assign half_lane = addr_lo_i[1] ? rdata_i[31:16] : rdata_i[15:0];

    // ==================================================================
    // extension per load type
    // ==================================================================

    always_comb begin
        case (opcode_i)
            OP_LB:  load_val_o = {{(XLEN-8){byte_lane[7]}}, byte_lane};
            OP_LBU: load_val_o = {{(XLEN-8){1'b0}}, byte_lane};
            // misaligned half gives zero
            OP_LH:  load_val_o = half_ok ? {{(XLEN-16){half_lane[15]}}, half_lane} : '0;
            OP_LHU: load_val_o = half_ok ? {{(XLEN-16){1'b0}}, half_lane} : '0;
            OP_LW:  load_val_o = rdata_i;
            // not a load
            default: load_val_o = '0;
        endcase
    end

    // misaligned half loads never leak lane data
    a_half_misaligned_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        ((opcode_i inside {OP_LH, OP_LHU}) && addr_lo_i[0]) |-> (load_val_o == '0)
    );

endmodule

// ==== hw/next_pc_calc.sv ====
module next_pc_calc (
    input  logic                  clk,
    input  logic                  rst_n,
    input  barrel_wb_pkg::wb_in_t wb_i,
    output barrel_wb_pkg::npc_t   npc_o
);
    import barrel_wb_pkg::*;

    word_t rel_target;
    word_t jalr_sum;
    logic  br_taken;

    // ==================================================================
    // candidate targets
    // ==================================================================

    // jal and taken branch share the pc-relative adder
    assign rel_target = wb_i.pc + wb_i.imm;
    // register-indirect for jalr
    assign jalr_sum   = wb_i.rs1 + wb_i.imm;
    // comparator result from the alu
    assign br_taken   = wb_i.alu_res[0];

    // ==================================================================
    // redirect decision
    // ==================================================================

    always_comb begin
        npc_o.has_new_pc = 1'b0;
        npc_o.save_pc    = 1'b0;
        // return address, pc of the next instruction
        npc_o.link       = wb_i.pc + word_t'(PC_STEP);
        npc_o.target     = rel_target;
        case (wb_i.opcode)
            OP_JAL: begin
                npc_o.has_new_pc = 1'b1;
                npc_o.save_pc    = 1'b1;
            end
            OP_JALR: begin
                npc_o.has_new_pc = 1'b1;
                npc_o.save_pc    = 1'b1;
                // lsb forced low per rv32 jalr
                npc_o.target     = {jalr_sum[XLEN-1:1], 1'b0};
            end
            OP_BRANCH: begin
                npc_o.has_new_pc = br_taken;
            end
            default: begin
                npc_o.has_new_pc = 1'b0;
            end
        endcase
    end

    a_jalr_target_even: assert property (
        @(posedge clk) disable iff (!rst_n)
        (wb_i.opcode == OP_JALR) |-> (npc_o.target[0] == 1'b0)
    );

    // a link write always comes with a redirect
    a_save_implies_redirect: assert property (
        @(posedge clk) disable iff (!rst_n)
        npc_o.save_pc |-> npc_o.has_new_pc
    );

endmodule

// ==== hw/regfile_write_stage.sv ====
module regfile_write_stage (
    input  logic                      clk,
    input  logic                      rst_n,
    input  barrel_wb_pkg::wb_in_t     wb_i,
    input  barrel_wb_pkg::word_t      load_val_i,
    input  barrel_wb_pkg::npc_t       npc_i,
    output barrel_wb_pkg::rf_write_t  rf_write_o,
    output barrel_wb_pkg::pc_update_t pc_update_o
);
    import barrel_wb_pkg::*;

    logic       wr_skip;
    logic       is_load;
    word_t      wr_data;
    rf_write_t  rf_next;
    pc_update_t pc_next;

    // ==================================================================
    // write classification
    // ==================================================================

    // branches, stores and nop leave the register file alone
    assign wr_skip = wb_i.opcode inside {OP_BRANCH, OP_SB, OP_SH, OP_SW, OP_NOP};

    assign is_load = wb_i.opcode inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};

    // write data priority
    // lui imm, then link, then load, then alu
    always_comb begin
        if (wb_i.opcode == OP_LUI) begin
            wr_data = wb_i.imm;
        end else if (npc_i.save_pc) begin
            wr_data = npc_i.link;
        end else if (is_load) begin
            wr_data = load_val_i;
        end else begin
            wr_data = wb_i.alu_res;
        end
    end

    // ==================================================================
    // next register values
    // ==================================================================

    always_comb begin
        rf_next.wen  = !wr_skip;
        // hart tag follows the slot either way
        rf_next.hart = wb_i.hart;
        // addr and data zeroed on skipped slots
        rf_next.addr = wr_skip ? '0 : wb_i.rd;
        rf_next.data = wr_skip ? '0 : wr_data;
    end

    // redirect target or the slot's own pc
    always_comb begin
        pc_next.computed = npc_i.has_new_pc;
        pc_next.hart     = wb_i.hart;
        pc_next.pc       = npc_i.has_new_pc ? npc_i.target : wb_i.pc;
    end

    // ==================================================================
    // output registers
    // ==================================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rf_write_o  <= '0;
            pc_update_o <= '0;
        end else begin
            rf_write_o  <= rf_next;
            pc_update_o <= pc_next;
        end
    end

    // ==================================================================
    // checks
    // ==================================================================

    // skipped slot never shows a write on the registered port
    a_skip_no_wen: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr_skip |=> !rf_write_o.wen
    );

endmodule

// ==== tb.f ====
hw/barrel_wb_pkg.sv
hw/load_align.sv
hw/next_pc_calc.sv
hw/regfile_write_stage.sv
hw/barrel_wb_top.sv
verif/tb_barrel_wb.sv

// ==== verif/tb_barrel_wb.sv ====
module tb_barrel_wb;
    timeunit 1ns;
    timeprecision 1ps;

    import barrel_wb_pkg::*;

    localparam int unsigned RESET_CYCLES = 5;
    localparam int unsigned NUM_DIRECTED = 30;
    localparam int unsigned NUM_RANDOM   = 300;
    // reset, every slot, drain and some margin
    localparam int unsigned MAX_CYCLES   = RESET_CYCLES + NUM_DIRECTED + NUM_RANDOM + 65;
    // negative bytes 81 8c f0 and positive byte 7f
    // halves 7f81 positive and f08c negative
    localparam word_t       LOAD_WORD    = 32'hf08c_7f81;

    logic       clk;
    logic       rst_n;
    wb_in_t     wb_in;
    word_t      dmem_rdata;
    rf_write_t  rf_write;
    pc_update_t pc_update;

    // model of the slot now on the inputs
    rf_write_t  exp_rf;
    pc_update_t exp_pc;
    // model of the slot the outputs show now
    rf_write_t  chk_rf;
    pc_update_t chk_pc;
    opcode_e    chk_op;

    int unsigned value_errors;
    int unsigned other_errors;
    int unsigned cycles;

    opcode_e load_ops[5]  = '{OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
    opcode_e other_ops[8] = '{OP_ALU, OP_LUI, OP_JAL, OP_JALR, OP_SB, OP_SH, OP_SW, OP_NOP};

    barrel_wb_top barrel_wb_top_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .wb_i         (wb_in),
        .dmem_rdata_i (dmem_rdata),
        .rf_write_o   (rf_write),
        .pc_update_o  (pc_update)
    );

    // ==================================================================
    // reference model
    // ==================================================================

    // shift the addressed byte down to bit 0, then extend
    function automatic word_t load_value(opcode_e op, logic [1:0] lo, word_t rdata);
        word_t shifted;
        shifted = rdata >> (8 * lo);
        case (op)
            OP_LW:   return rdata;
            OP_LB:   return {{24{shifted[7]}}, shifted[7:0]};
            OP_LBU:  return {24'h0, shifted[7:0]};
            // odd offset half loads read as zero
            OP_LH:   return lo[0] ? '0 : {{16{shifted[15]}}, shifted[15:0]};
            OP_LHU:  return lo[0] ? '0 : {16'h0, shifted[15:0]};
            default: return '0;
        endcase
    endfunction

    function automatic rf_write_t expect_rf(wb_in_t s, word_t rdata);
        rf_write_t r;
        r      = '0;
        r.hart = s.hart;
        r.wen  = !(s.opcode inside {OP_BRANCH, OP_SB, OP_SH, OP_SW, OP_NOP});
        if (r.wen) begin
            r.addr = s.rd;
            if (s.opcode == OP_LUI) begin
                r.data = s.imm;
            end else if (s.opcode inside {OP_JAL, OP_JALR}) begin
                // return address
                r.data = s.pc + 32'd4;
            end else if (s.opcode inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU}) begin
                r.data = load_value(s.opcode, s.addr_lo, rdata);
            end else begin
                r.data = s.alu_res;
            end
        end
        return r;
    endfunction

    function automatic pc_update_t expect_pc(wb_in_t s);
        pc_update_t p;
        p.hart     = s.hart;
        p.computed = 1'b0;
        p.pc       = s.pc;
        if (s.opcode == OP_JAL || (s.opcode == OP_BRANCH && s.alu_res[0])) begin
            p.computed = 1'b1;
            p.pc       = s.pc + s.imm;
        end else if (s.opcode == OP_JALR) begin
            p.computed = 1'b1;
            p.pc       = (s.rs1 + s.imm) & 32'hffff_fffe;
        end
        return p;
    endfunction

    function automatic string behavior_of(opcode_e op);
        case (op)
            OP_ALU, OP_LUI:                    return "alu_lui_write";
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: return "load_extend";
            OP_BRANCH:                         return "branch_redirect";
            OP_JAL, OP_JALR:                   return "jump_link";
            default:                           return "store_nop_skip";
        endcase
    endfunction

    // ==================================================================
    // stimulus helpers
    // ==================================================================

    function automatic wb_in_t random_slot(opcode_e op, logic [1:0] lo);
        wb_in_t s;
        s.hart    = hart_t'($urandom);
        s.opcode  = op;
        s.rd      = reg_addr_t'($urandom);
        s.alu_res = $urandom;
        s.rs1     = $urandom;
        s.imm     = $urandom;
        s.pc      = $urandom;
        s.addr_lo = lo;
        return s;
    endfunction

    // one slot per falling edge
    // model tracks the new inputs
    task automatic drive_slot(input wb_in_t s, input word_t rdata);
        @(negedge clk);
        // outputs at the next rising edge show the slot now leaving
        chk_rf     = exp_rf;
        chk_pc     = exp_pc;
        chk_op     = wb_in.opcode;
        wb_in      = s;
        dmem_rdata = rdata;
        exp_rf     = expect_rf(s, rdata);
        exp_pc     = expect_pc(s);
    endtask

    task automatic end_run();
        $display("summary: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    endtask

    // ==================================================================
    // checks
    // ==================================================================

    // outputs quiet through reset and the first cycle after
    a_reset_quiet: assert property (
        @(posedge clk) !rst_n |=> (!rf_write.wen && !pc_update.computed)
    ) else begin
        other_errors++;
        $display("register write or pc redirect seen during or right after reset");
    end

    a_rf_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        $past(rst_n) |-> (rf_write == $past(exp_rf))
    ) else begin
        value_errors++;
        $display("FAILED %s rf_write: expected %h actual %h",
                 behavior_of(chk_op), chk_rf, $sampled(rf_write));
    end

    a_pc_update: assert property (
        @(posedge clk) disable iff (!rst_n)
        $past(rst_n) |-> (pc_update == $past(exp_pc))
    ) else begin
        value_errors++;
        $display("FAILED %s pc_update: expected %h actual %h",
                 behavior_of(chk_op), chk_pc, $sampled(pc_update));
    end

    // ==================================================================
    // clock, timeout and main sequence
    // ==================================================================

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            other_errors++;
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            end_run();
        end
    end

    initial begin
        wb_in_t s;
        void'($urandom(32'h66fabd8b));
        value_errors = 0;
        other_errors = 0;
        cycles       = 0;
        rst_n        = 1'b0;
        // a live jump sits on the inputs through reset
        s            = random_slot(OP_JAL, 2'd0);
        wb_in        = s;
        dmem_rdata   = $urandom;
        exp_rf       = expect_rf(s, dmem_rdata);
        exp_pc       = expect_pc(s);
        chk_rf       = '0;
        chk_pc       = '0;
        chk_op       = OP_NOP;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        // every load with every byte offset
        foreach (load_ops[i]) begin
            for (int lo = 0; lo < 4; lo++) begin
                drive_slot(random_slot(load_ops[i], 2'(lo)), LOAD_WORD);
            end
        end
        // branch not taken, then taken
        for (int taken = 0; taken < 2; taken++) begin
            s            = random_slot(OP_BRANCH, 2'd0);
            s.alu_res[0] = taken[0];
            drive_slot(s, $urandom);
        end
        foreach (other_ops[i]) begin
            drive_slot(random_slot(other_ops[i], 2'($urandom)), $urandom);
        end
        // random mix over the whole opcode set
        repeat (NUM_RANDOM) begin
            s = random_slot(opcode_e'($urandom_range(0, int'(OP_SW))), 2'($urandom));
            drive_slot(s, $urandom);
        end
        // drain the last slot through the check
        drive_slot(random_slot(OP_NOP, 2'd0), '0);
        @(posedge clk);
        @(negedge clk);
        end_run();
    end

endmodule
